// File: src/huf_comp_cfg.svh
// huf compressor wrapper configuration
// stream widths, APB register map and reset defaults
`ifndef HUF_COMP_CFG_SVH
`define HUF_COMP_CFG_SVH

`define HUF_DATA_W        64
`define HUF_STRB_W        8
`define HUF_TID_W         4
`define HUF_MODID_W       5
`define HUF_CNT_W         24
`define HUF_APB_AW        8

// default frame size limit in bytes
`define HUF_MAX_FRAME_RST 24'd4096

`define HUF_REG_CTRL      8'h00
`define HUF_REG_FRAMES    8'h04
`define HUF_REG_BYTES     8'h08
`define HUF_REG_INT_STAT  8'h0C
`define HUF_REG_INT_MASK  8'h10
`define HUF_REG_MAX_FRAME 8'h14

`endif

// File: src/huf_comp_pkg.sv
// huf compressor shared types
// stream beat and scheduler update payloads, register map
`include "huf_comp_cfg.svh"

package huf_comp_pkg;

  typedef struct packed {
    logic [`HUF_DATA_W-1:0] tdata;
    logic [`HUF_STRB_W-1:0] tstrb;
    logic [1:0]             tuser;
    logic [`HUF_TID_W-1:0]  tid;
    logic                   tlast;
  } huf_beat_t;

  // one update per frame to the downstream scheduler
  typedef struct packed {
    logic [`HUF_TID_W-1:0]   tid;
    logic [`HUF_CNT_W-1:0]   bytes;
    logic [`HUF_MODID_W-1:0] mod_id;
  } huf_sched_t;

  typedef logic [$clog2(`HUF_STRB_W):0] huf_bb_t; // 0..8 bytes per beat

  typedef enum logic [`HUF_APB_AW-1:0] {
    REG_CTRL      = `HUF_REG_CTRL,
    REG_FRAMES    = `HUF_REG_FRAMES,
    REG_BYTES     = `HUF_REG_BYTES,
    REG_INT_STAT  = `HUF_REG_INT_STAT,
    REG_INT_MASK  = `HUF_REG_INT_MASK,
    REG_MAX_FRAME = `HUF_REG_MAX_FRAME
  } huf_reg_e;

endpackage

// File: src/huf_comp_rst_sync.sv
// huf compressor reset synchronizer
// asserts asynchronously, releases two clocks after rst_n rises
`timescale 1ns/10ps

module huf_comp_rst_sync (
  input  logic clk,
  input  logic rst_n,
  output logic rst_sync_n
);

  logic meta_n;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      meta_n     <= 1'b0;
      rst_sync_n <= 1'b0;
    end
    else
    begin
      meta_n     <= 1'b1;
      rst_sync_n <= meta_n;
    end
  end

endmodule

// File: src/huf_comp_skid.sv
// two-entry skid buffer
// registered valid and ready for any payload type
`timescale 1ns/10ps

module huf_comp_skid #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic     skid_valid;
  payload_t skid_data;
  logic     out_free;
  logic     in_fire;

  assign in_ready = ~skid_valid; // straight from a flop
  assign in_fire  = in_valid & in_ready;
  assign out_free = ~out_valid | out_ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end
    else if (out_free)
    begin
      out_valid  <= skid_valid | in_fire;
      skid_valid <= 1'b0;
    end
    else if (in_fire)
      skid_valid <= 1'b1; // output stalled, park it
  end

  always_ff @(posedge clk)
  begin
    if (out_free)
      out_data <= skid_valid ? skid_data : in_data;
    else if (in_fire)
      skid_data <= in_data;
  end

  // held item must not change under back-pressure
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: src/huf_comp_core.sv
// huf compressor stream core
// passes framed 64-bit beats through a skid buffer, counts bytes per
// frame, patches the count into the footer beat and issues one
// scheduler update per frame
`timescale 1ns/10ps
`include "huf_comp_cfg.svh"

module huf_comp_core
  import huf_comp_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    ib_tvalid,
  input  logic [`HUF_DATA_W-1:0]  ib_tdata,
  input  logic [`HUF_STRB_W-1:0]  ib_tstrb,
  input  logic [1:0]              ib_tuser,
  input  logic [`HUF_TID_W-1:0]   ib_tid,
  input  logic                    ib_tlast,
  output logic                    ib_tready,

  output logic                    ob_tvalid,
  output logic [`HUF_DATA_W-1:0]  ob_tdata,
  output logic [`HUF_STRB_W-1:0]  ob_tstrb,
  output logic [1:0]              ob_tuser,
  output logic [`HUF_TID_W-1:0]   ob_tid,
  output logic                    ob_tlast,
  input  logic                    ob_tready,

  input  logic [`HUF_MODID_W-1:0] out_module_id,
  input  logic                    su_ready,
  output logic                    sch_valid,
  output huf_sched_t              sch_data,

  input  logic                    patch_en,
  output logic                    frame_done,
  output logic [`HUF_CNT_W-1:0]   frame_bytes,
  output huf_bb_t                 beat_bytes,
  output logic                    beat_acc
);

  localparam int FTR_LSB = 20; // footer byte count at 43:20
  localparam int CNT_W   = `HUF_CNT_W;

  huf_beat_t            beat_in;
  huf_beat_t            beat_out;
  huf_sched_t           sch_in;
  logic                 beat_in_ready;
  logic                 sch_in_ready;
  logic                 sch_ok;
  logic [CNT_W-1:0]     frame_cnt;
  logic [CNT_W-1:0]     cnt_incl;

  // a tlast beat needs room for its update too
  assign sch_ok    = ~ib_tlast | sch_in_ready;
  assign ib_tready = beat_in_ready & sch_ok;
  assign beat_acc  = ib_tvalid & ib_tready;

  always_comb
  begin
    beat_bytes = '0;
    for (int i = 0; i < `HUF_STRB_W; i++)
    begin
      beat_bytes = beat_bytes + huf_bb_t'(ib_tstrb[i]);
    end
  end

  assign cnt_incl    = frame_cnt + CNT_W'(beat_bytes);
  assign frame_bytes = cnt_incl;
  assign frame_done  = beat_acc & ib_tlast;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      frame_cnt <= '0;
    else if (beat_acc)
      frame_cnt <= ib_tlast ? '0 : cnt_incl;
  end

  always_comb
  begin
    beat_in.tdata = ib_tdata;
    if (ib_tlast && patch_en)
      beat_in.tdata[FTR_LSB +: CNT_W] = cnt_incl;
    beat_in.tstrb = ib_tstrb;
    beat_in.tuser = ib_tuser;
    beat_in.tid   = ib_tid;
    beat_in.tlast = ib_tlast;
  end

  assign sch_in.tid    = ib_tid;
  assign sch_in.bytes  = cnt_incl;
  assign sch_in.mod_id = out_module_id;

  huf_comp_skid #(.payload_t(huf_beat_t)) u_beat_skid (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (ib_tvalid & sch_ok),
    .in_data   (beat_in),
    .in_ready  (beat_in_ready),
    .out_valid (ob_tvalid),
    .out_data  (beat_out),
    .out_ready (ob_tready)
  );

  huf_comp_skid #(.payload_t(huf_sched_t)) u_sch_skid (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (frame_done),
    .in_data   (sch_in),
    .in_ready  (sch_in_ready),
    .out_valid (sch_valid),
    .out_data  (sch_data),
    .out_ready (su_ready)
  );

  assign ob_tdata = beat_out.tdata;
  assign ob_tstrb = beat_out.tstrb;
  assign ob_tuser = beat_out.tuser;
  assign ob_tid   = beat_out.tid;
  assign ob_tlast = beat_out.tlast;

  // empty beats would break the per-frame byte count
  a_strb_nz: assert property (@(posedge clk) disable iff (!rst_n)
    ib_tvalid |-> ib_tstrb != '0);

endmodule

// File: src/huf_comp_regfile.sv
// huf compressor register file
// APB slave with control, frame/byte statistics, frame size limit
// and the interrupt status/mask pair behind irq
`timescale 1ns/10ps
`include "huf_comp_cfg.svh"

module huf_comp_regfile
  import huf_comp_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`HUF_APB_AW-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,

  input  logic                   frame_done,
  input  logic [`HUF_CNT_W-1:0]  frame_bytes,
  input  huf_bb_t                beat_bytes,
  input  logic                   beat_acc,
  output logic                   patch_en,
  output logic                   irq
);

  logic                  mapped;
  logic                  wr;
  logic [31:0]           frames_r;
  logic [31:0]           bytes_r;
  logic [1:0]            int_stat;
  logic [1:0]            int_mask;
  logic [`HUF_CNT_W-1:0] max_frame;
  logic [1:0]            int_set;
  logic [1:0]            int_clr;

  always_comb
  begin
    mapped = 1'b1;
    prdata = '0;
    case (paddr)
      REG_CTRL:      prdata = {31'b0, patch_en};
      REG_FRAMES:    prdata = frames_r;
      REG_BYTES:     prdata = bytes_r;
      REG_INT_STAT:  prdata = {30'b0, int_stat};
      REG_INT_MASK:  prdata = {30'b0, int_mask};
      REG_MAX_FRAME: prdata = {{(32 - `HUF_CNT_W){1'b0}}, max_frame};
      default:       mapped = 1'b0;
    endcase
  end

  assign pready  = 1'b1; // no wait states
  assign pslverr = psel & penable & ~mapped;
  assign wr      = psel & penable & pwrite & mapped;

  // bit 1 is the oversize flag
  assign int_set = {frame_done & (frame_bytes > max_frame), frame_done};
  assign int_clr = (wr && paddr == REG_INT_STAT) ? pwdata[1:0] : 2'b00;
  assign irq     = |(int_stat & int_mask);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      patch_en  <= 1'b1;
      frames_r  <= '0;
      bytes_r   <= '0;
      int_stat  <= '0;
      int_mask  <= '0;
      max_frame <= `HUF_MAX_FRAME_RST;
    end
    else
    begin
      if (frame_done)
        frames_r <= frames_r + 32'd1;
      if (beat_acc)
        bytes_r <= bytes_r + 32'(beat_bytes);
      int_stat <= (int_stat & ~int_clr) | int_set; // set wins
      if (wr)
      begin
        case (paddr)
          REG_CTRL:      patch_en  <= pwdata[0];
          REG_INT_MASK:  int_mask  <= pwdata[1:0];
          REG_MAX_FRAME: max_frame <= pwdata[`HUF_CNT_W-1:0];
          default:       ;
        endcase
      end
    end
  end

  // access phase always follows a setup phase
  a_apb_setup: assert property (@(posedge clk) disable iff (!rst_n)
    penable |-> $past(psel && !penable));

endmodule

// File: src/huf_comp.sv
// huf compressor wrapper top
// reset synchronizer, stream core and APB register file
`timescale 1ns/10ps
`include "huf_comp_cfg.svh"

module huf_comp
  import huf_comp_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    ib_tvalid,
  input  logic [`HUF_DATA_W-1:0]  ib_tdata,
  input  logic [`HUF_STRB_W-1:0]  ib_tstrb,
  input  logic [1:0]              ib_tuser,
  input  logic [`HUF_TID_W-1:0]   ib_tid,
  input  logic                    ib_tlast,
  output logic                    ib_tready,

  output logic                    ob_tvalid,
  output logic [`HUF_DATA_W-1:0]  ob_tdata,
  output logic [`HUF_STRB_W-1:0]  ob_tstrb,
  output logic [1:0]              ob_tuser,
  output logic [`HUF_TID_W-1:0]   ob_tid,
  output logic                    ob_tlast,
  input  logic                    ob_tready,

  input  logic [`HUF_MODID_W-1:0] out_module_id,
  input  logic                    su_ready,
  output logic                    sch_valid,
  output huf_sched_t              sch_data,

  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`HUF_APB_AW-1:0]  paddr,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic                    irq
);

  logic                  rst_sync_n;
  logic                  patch_en;
  logic                  frame_done;
  logic [`HUF_CNT_W-1:0] frame_bytes;
  huf_bb_t               beat_bytes;
  logic                  beat_acc;

  huf_comp_rst_sync u_rst_sync (
    .clk        (clk),
    .rst_n      (rst_n),
    .rst_sync_n (rst_sync_n)
  );

  huf_comp_core u_core (
    .clk           (clk),
    .rst_n         (rst_sync_n),
    .ib_tvalid     (ib_tvalid),
    .ib_tdata      (ib_tdata),
    .ib_tstrb      (ib_tstrb),
    .ib_tuser      (ib_tuser),
    .ib_tid        (ib_tid),
    .ib_tlast      (ib_tlast),
    .ib_tready     (ib_tready),
    .ob_tvalid     (ob_tvalid),
    .ob_tdata      (ob_tdata),
    .ob_tstrb      (ob_tstrb),
    .ob_tuser      (ob_tuser),
    .ob_tid        (ob_tid),
    .ob_tlast      (ob_tlast),
    .ob_tready     (ob_tready),
    .out_module_id (out_module_id),
    .su_ready      (su_ready),
    .sch_valid     (sch_valid),
    .sch_data      (sch_data),
    .patch_en      (patch_en),
    .frame_done    (frame_done),
    .frame_bytes   (frame_bytes),
    .beat_bytes    (beat_bytes),
    .beat_acc      (beat_acc)
  );

  huf_comp_regfile u_regfile (
    .clk         (clk),
    .rst_n       (rst_sync_n),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .frame_done  (frame_done),
    .frame_bytes (frame_bytes),
    .beat_bytes  (beat_bytes),
    .beat_acc    (beat_acc),
    .patch_en    (patch_en),
    .irq         (irq)
  );

endmodule

// File: verification/huf_comp_tb.sv
// huf compressor testbench
// drives framed beats and APB accesses, models the expected beats and
// scheduler updates, and checks them as they leave the DUT
`timescale 1ns/10ps
`include "huf_comp_cfg.svh"

module huf_comp_tb
  import huf_comp_pkg::*;
();

  localparam int CNT_W      = `HUF_CNT_W;
  localparam int FTR_LSB    = 20;   // footer count at 43:20
  localparam int BEAT_WAIT  = 200;  // cycles
  localparam int DRAIN_WAIT = 1000;
  localparam int APB_WAIT   = 16;

  logic                    clk;
  logic                    rst_n;
  logic                    ib_tvalid;
  logic [`HUF_DATA_W-1:0]  ib_tdata;
  logic [`HUF_STRB_W-1:0]  ib_tstrb;
  logic [1:0]              ib_tuser;
  logic [`HUF_TID_W-1:0]   ib_tid;
  logic                    ib_tlast;
  logic                    ib_tready;
  logic                    ob_tvalid;
  logic [`HUF_DATA_W-1:0]  ob_tdata;
  logic [`HUF_STRB_W-1:0]  ob_tstrb;
  logic [1:0]              ob_tuser;
  logic [`HUF_TID_W-1:0]   ob_tid;
  logic                    ob_tlast;
  logic                    ob_tready;
  logic [`HUF_MODID_W-1:0] out_module_id;
  logic                    su_ready;
  logic                    sch_valid;
  huf_sched_t              sch_data;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`HUF_APB_AW-1:0]  paddr;
  logic [31:0]             pwdata;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    irq;

  huf_beat_t             ob_beat;
  huf_beat_t             exp_b;
  huf_beat_t             in_b;
  huf_sched_t            exp_u;
  huf_sched_t            in_u;
  huf_beat_t             exp_beats[$];
  huf_sched_t            exp_sch[$];
  logic [CNT_W-1:0]      run_sum;
  logic [31:0]           tot_frames;
  logic [31:0]           tot_bytes;
  logic                  patch_model;
  logic                  stall_on;
  logic [`HUF_TID_W-1:0] next_tid;
  logic [31:0]           rdy_rnd;
  integer                seed;
  string                 test_name;
  int                    main_errs;
  int                    sb_errs;
  int                    ob_hold_errs;
  int                    sch_hold_errs;
  int                    beats_seen;
  int                    upds_seen;

  huf_comp u_dut (.*);

  assign ob_beat = {ob_tdata, ob_tstrb, ob_tuser, ob_tid, ob_tlast};

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // random back-pressure on both outputs
  initial
  begin
    ob_tready = 1'b1;
    su_ready  = 1'b1;
    forever
    begin
      @(posedge clk);
      #1;
      rdy_rnd   = rand32();
      ob_tready = !stall_on || rdy_rnd[1:0] != 2'b00;
      su_ready  = !stall_on || rdy_rnd[5:4] != 2'b00;
    end
  end

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  // reference model and output compare
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      run_sum    = '0;
      tot_frames = '0;
      tot_bytes  = '0;
    end
    else
    begin
      if (ob_tvalid && ob_tready)
      begin
        if (exp_beats.size() == 0)
        begin
          sb_errs++;
          $display("output beat appeared with no input beat pending");
        end
        else
        begin
          exp_b = exp_beats.pop_front();
          beats_seen++;
          assert (ob_beat == exp_b) else
          begin
            sb_errs++;
            $display("Error %s expected %h actual %h", test_name, exp_b, ob_beat);
          end
        end
      end
      if (sch_valid && su_ready)
      begin
        if (exp_sch.size() == 0)
        begin
          sb_errs++;
          $display("scheduler update appeared with no frame pending");
        end
        else
        begin
          exp_u = exp_sch.pop_front();
          upds_seen++;
          assert (sch_data == exp_u) else
          begin
            sb_errs++;
            $display("Error %s expected %h actual %h", test_name, exp_u, sch_data);
          end
        end
      end
      if (ib_tvalid && ib_tready)
      begin
        in_b      = {ib_tdata, ib_tstrb, ib_tuser, ib_tid, ib_tlast};
        run_sum   = run_sum + CNT_W'($countones(ib_tstrb));
        tot_bytes = tot_bytes + 32'($countones(ib_tstrb));
        if (ib_tlast)
        begin
          if (patch_model)
            in_b.tdata[FTR_LSB +: CNT_W] = run_sum;
          in_u.tid    = ib_tid;
          in_u.bytes  = run_sum;
          in_u.mod_id = out_module_id;
          exp_sch.push_back(in_u);
          tot_frames = tot_frames + 32'd1;
          run_sum    = '0;
        end
        exp_beats.push_back(in_b);
      end
    end
  end

  a_ob_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ob_tvalid && !ob_tready |=> ob_tvalid && $stable(ob_beat)) else
  begin
    ob_hold_errs++;
    $display("output beat dropped or changed while stalled");
  end

  a_sch_hold: assert property (@(posedge clk) disable iff (!rst_n)
    sch_valid && !su_ready |=> sch_valid && $stable(sch_data)) else
  begin
    sch_hold_errs++;
    $display("scheduler update dropped or changed while stalled");
  end

  task automatic expect_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act == exp) else
    begin
      main_errs++;
      $display("Error %s %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic apb_transfer(input logic wr, input logic [`HUF_APB_AW-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int waits;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    waits   = 0;
    do
    begin
      @(posedge clk);
      waits++;
    end while (!pready && waits < APB_WAIT);
    if (!pready)
    begin
      main_errs++;
      $display("APB access to %0h got no pready", addr);
    end
    rdata = prdata;
    err   = pslverr;
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [`HUF_APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_transfer(1'b1, addr, data, rd, err);
  endtask

  task automatic read_reg(input logic [`HUF_APB_AW-1:0] addr, output logic [31:0] rd,
                          output logic err);
    apb_transfer(1'b0, addr, 32'd0, rd, err);
  endtask

  task automatic send_frame(input logic [`HUF_TID_W-1:0] tid, input int nbeats,
                            input logic full);
    logic [31:0] r;
    int          waits;
    @(posedge clk);
    #1;
    for (int i = 0; i < nbeats; i++)
    begin
      r = rand32();
      if (stall_on && r[7:6] == 2'b00)
      begin
        ib_tvalid = 1'b0; // idle gap
        @(posedge clk);
        #1;
      end
      ib_tdata  = {rand32(), rand32()};
      ib_tstrb  = full ? 8'hff : r[15:8];
      if (ib_tstrb == '0)
        ib_tstrb = 8'h01;
      ib_tuser  = r[17:16];
      ib_tid    = tid;
      ib_tlast  = (i == nbeats - 1);
      ib_tvalid = 1'b1;
      waits     = 0;
      do
      begin
        @(posedge clk);
        waits++;
      end while (!ib_tready && waits < BEAT_WAIT);
      if (!ib_tready)
      begin
        main_errs++;
        $display("input beat of frame %0d was never accepted", tid);
      end
      #1;
    end
    ib_tvalid = 1'b0;
    ib_tlast  = 1'b0;
  endtask

  task automatic send_batch(input int frames);
    logic [31:0] r;
    for (int f = 0; f < frames; f++)
    begin
      r = rand32();
      send_frame(next_tid, 1 + int'(r[2:0] % 3'd6), 1'b0);
      next_tid++;
    end
  endtask

  task automatic wait_drain();
    int waits;
    waits = 0;
    while ((exp_beats.size() != 0 || exp_sch.size() != 0) && waits < DRAIN_WAIT)
    begin
      @(posedge clk);
      #1;
      waits++;
    end
    if (exp_beats.size() != 0 || exp_sch.size() != 0)
    begin
      main_errs++;
      $display("%0d beats and %0d updates never left the DUT",
               exp_beats.size(), exp_sch.size());
    end
  endtask

  initial
  begin
    logic [31:0] rd;
    logic        err;
    int          total;
    seed          = 32'hb600_6ee1;
    rst_n         = 1'b0;
    ib_tvalid     = 1'b0;
    ib_tdata      = '0;
    ib_tstrb      = '0;
    ib_tuser      = '0;
    ib_tid        = '0;
    ib_tlast      = 1'b0;
    out_module_id = 5'h13;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    patch_model   = 1'b1;
    stall_on      = 1'b0;
    next_tid      = '0;
    test_name     = "reset";
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (3) @(posedge clk); // sync release
    #1;
    expect_value("ob_tvalid", 32'd0, 32'(ob_tvalid));
    expect_value("sch_valid", 32'd0, 32'(sch_valid));
    expect_value("irq", 32'd0, 32'(irq));
    expect_value("pslverr", 32'd0, 32'(pslverr));
    expect_value("ib_tready", 32'd1, 32'(ib_tready));

    test_name = "patch_on";
    send_batch(4);
    wait_drain();

    test_name = "patch_off";
    write_reg(`HUF_REG_CTRL, 32'd0);
    patch_model = 1'b0;
    read_reg(`HUF_REG_CTRL, rd, err);
    expect_value("ctrl", 32'd0, rd);
    send_batch(3);
    wait_drain();
    write_reg(`HUF_REG_CTRL, 32'd1);
    patch_model = 1'b1;

    test_name     = "stalls";
    out_module_id = 5'h0a;
    stall_on      = 1'b1;
    send_batch(8);
    wait_drain();
    stall_on = 1'b0;

    test_name = "stats";
    read_reg(`HUF_REG_FRAMES, rd, err);
    expect_value("frames", tot_frames, rd);
    expect_value("frames pslverr", 32'd0, 32'(err));
    read_reg(`HUF_REG_BYTES, rd, err);
    expect_value("bytes", tot_bytes, rd);
    read_reg(8'h40, rd, err);
    expect_value("unmapped pslverr", 32'd1, 32'(err));

    test_name = "irq";
    write_reg(`HUF_REG_MAX_FRAME, 32'd8);
    write_reg(`HUF_REG_INT_STAT, 32'd3); // old done flags
    write_reg(`HUF_REG_INT_MASK, 32'd3);
    expect_value("irq idle", 32'd0, 32'(irq));
    send_frame(next_tid, 3, 1'b1); // 24 bytes
    wait_drain();
    read_reg(`HUF_REG_INT_STAT, rd, err);
    expect_value("int_stat", 32'd3, rd);
    expect_value("irq raised", 32'd1, 32'(irq));
    write_reg(`HUF_REG_INT_STAT, 32'd3);
    expect_value("irq cleared", 32'd0, 32'(irq));
    read_reg(`HUF_REG_INT_STAT, rd, err);
    expect_value("int_stat cleared", 32'd0, rd);

    total = main_errs + sb_errs + ob_hold_errs + sch_hold_errs;
    $display("beats %0d, updates %0d, errors: sequence %0d, compare %0d, hold %0d/%0d",
             beats_seen, upds_seen, main_errs, sb_errs, ob_hold_errs, sch_hold_errs);
    if (total == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: all.f
+incdir+src
src/huf_comp_pkg.sv
src/huf_comp_rst_sync.sv
src/huf_comp_skid.sv
src/huf_comp_core.sv
src/huf_comp_regfile.sv
src/huf_comp.sv
verification/huf_comp_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the huf compressor testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps --top-module huf_comp_tb \
  -f all.f -o huf_comp_sim || exit 1
out=$(./obj_dir/huf_comp_sim)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
